/* all.f */
+incdir+common
common/pic_pkg.sv
command/command_decoder.sv
interrupt/priority_resolver.sv
interrupt/ack_sequencer.sv
src/bus_output.sv
src/pic_top.sv
testbench/tb_clock.sv
testbench/tb_pic.sv

/* command/command_decoder.sv */
`default_nettype none

`include "pic_settings.svh"

module command_decoder (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           wr,
    input  wire logic           a0,
    input  wire pic_pkg::data_t din,
    output logic                init_clear,
    output logic                eoi_pulse,
    output logic                eoi_specific,
    output logic                eoi_rotate,
    output logic                set_priority,
    output logic                level_triggered,
    output logic                auto_eoi,
    output logic                read_isr,
    output pic_pkg::irq_vec_t   irq_mask,
    output pic_pkg::level_t     eoi_level,
    output pic_pkg::level_t     priority_level,
    output pic_pkg::vector_base_t vector_base
);

    pic_pkg::init_state_t state;
    logic                 needs_icw4;
    logic                 write_icw1;
    logic                 write_icw2;
    logic                 write_icw4;
    logic                 write_ocw1;
    logic                 write_ocw2;
    logic                 write_ocw3;
    logic [2:0]           ocw2_cmd;

    // ICW1 is recognized in any state and restarts the sequence
    assign write_icw1 = wr && !a0 && din[4];
    assign write_ocw2 = wr && !a0 && !din[4] && !din[3];
    assign write_ocw3 = wr && !a0 && !din[4] && din[3];
    assign write_icw2 = wr && a0 && (state == pic_pkg::INIT_WAIT_ICW2);
    assign write_icw4 = wr && a0 && (state == pic_pkg::INIT_WAIT_ICW4);
    assign write_ocw1 = wr && a0 && (state == pic_pkg::INIT_READY);

    assign ocw2_cmd = din[7:5];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= pic_pkg::INIT_READY;
        end else if (write_icw1) begin
            state <= pic_pkg::INIT_WAIT_ICW2;
        end else if (write_icw2) begin
            state <= needs_icw4 ? pic_pkg::INIT_WAIT_ICW4 : pic_pkg::INIT_READY;
        end else if (write_icw4) begin
            state <= pic_pkg::INIT_READY;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            level_triggered <= 1'b0;
            needs_icw4      <= 1'b0;
            vector_base     <= '0;
            auto_eoi        <= 1'b0;
            irq_mask        <= '1;
            read_isr        <= 1'b0;
        end else if (write_icw1) begin
            level_triggered <= din[3];
            needs_icw4      <= din[0];
            vector_base     <= '0;
            auto_eoi        <= 1'b0;
            irq_mask        <= '1;
            read_isr        <= 1'b0;
        end else begin
            if (write_icw2) begin
                vector_base <= din[`PIC_DATA_BITS-1:`PIC_LEVEL_BITS];
            end
            if (write_icw4) begin
                auto_eoi <= din[1];
            end
            if (write_ocw1) begin
                irq_mask <= din;
            end
            // RR bit gates the register select
            if (write_ocw3 && din[1]) begin
                read_isr <= din[0];
            end
        end
    end

    // OCW2 commands become single-cycle pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            init_clear   <= 1'b0;
            eoi_pulse    <= 1'b0;
            eoi_specific <= 1'b0;
            eoi_rotate   <= 1'b0;
            set_priority <= 1'b0;
        end else begin
            init_clear   <= write_icw1;
            eoi_pulse    <= write_ocw2 && ((ocw2_cmd == 3'b001) || (ocw2_cmd == 3'b011) ||
                                           (ocw2_cmd == 3'b101));
            eoi_specific <= write_ocw2 && (ocw2_cmd == 3'b011);
            eoi_rotate   <= write_ocw2 && (ocw2_cmd == 3'b101);
            set_priority <= write_ocw2 && (ocw2_cmd[2:1] == 2'b11);
        end
    end

    always_ff @(posedge clk) begin
        if (write_ocw2) begin
            eoi_level <= din[`PIC_LEVEL_BITS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || write_icw1) begin
            priority_level <= '1;
        end else if (write_ocw2) begin
            priority_level <= din[`PIC_LEVEL_BITS-1:0];
        end
    end

endmodule

`default_nettype wire

/* common/pic_pkg.sv */
`default_nettype none

`include "pic_settings.svh"

package pic_pkg;

    // One bit per request line
    typedef logic [`PIC_IRQ_COUNT-1:0] irq_vec_t;

    typedef logic [`PIC_LEVEL_BITS-1:0] level_t;

    typedef logic [`PIC_DATA_BITS-1:0] data_t;

    // Upper vector bits from ICW2
    typedef logic [`PIC_VECTOR_BASE_BITS-1:0] vector_base_t;

    // Initialization word sequence
    typedef enum logic [1:0] {
        INIT_READY,
        INIT_WAIT_ICW2,
        INIT_WAIT_ICW4
    } init_state_t;

    // Two-pulse INTA sequence of 8086 mode
    typedef enum logic [1:0] {
        ACK_IDLE,
        ACK_FIRST,
        ACK_SECOND
    } ack_state_t;

endpackage

`default_nettype wire

/* common/pic_settings.svh */
`ifndef PIC_SETTINGS_SVH
`define PIC_SETTINGS_SVH

// One request line per IR input
`define PIC_IRQ_COUNT 8

// Bits to encode one level
`define PIC_LEVEL_BITS 3

// CPU data bus
`define PIC_DATA_BITS 8

// ICW2 base field above the level bits
`define PIC_VECTOR_BASE_BITS 5

`endif

/* interrupt/ack_sequencer.sv */
`default_nettype none

module ack_sequencer (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           init_clear,
    input  wire logic           inta_n,
    input  wire logic           request_pending,
    output logic                ack_latch,
    output logic                ack_end,
    output logic                interrupt_to_cpu,
    output pic_pkg::ack_state_t ack_state
);

    logic inta_last;
    logic inta_fall;
    logic inta_rise;

    // Edges between the previous and the current sample of INTA
    assign inta_fall = inta_last && !inta_n;
    assign inta_rise = !inta_last && inta_n;

    always_ff @(posedge clk) begin
        if (rst) begin
            inta_last <= 1'b1;
        end else begin
            inta_last <= inta_n;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || init_clear) begin
            ack_state        <= pic_pkg::ACK_IDLE;
            ack_latch        <= 1'b0;
            ack_end          <= 1'b0;
            interrupt_to_cpu <= 1'b0;
        end else begin
            ack_latch <= 1'b0;
            ack_end   <= 1'b0;
            case (ack_state)
                pic_pkg::ACK_IDLE: begin
                    if (inta_fall) begin
                        ack_state <= pic_pkg::ACK_FIRST;
                        ack_latch <= 1'b1;
                    end else if (request_pending) begin
                        interrupt_to_cpu <= 1'b1;
                    end
                end
                pic_pkg::ACK_FIRST: begin
                    if (inta_rise) begin
                        ack_state <= pic_pkg::ACK_SECOND;
                    end
                end
                pic_pkg::ACK_SECOND: begin
                    // Vector goes out while this pulse is low
                    if (inta_rise) begin
                        ack_state        <= pic_pkg::ACK_IDLE;
                        ack_end          <= 1'b1;
                        interrupt_to_cpu <= 1'b0;
                    end
                end
                default: begin
                    ack_state <= pic_pkg::ACK_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* interrupt/priority_resolver.sv */
`default_nettype none

`include "pic_settings.svh"

module priority_resolver (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              init_clear,
    input  wire logic              level_triggered,
    input  wire logic              auto_eoi,
    input  wire logic              eoi_pulse,
    input  wire logic              eoi_specific,
    input  wire logic              eoi_rotate,
    input  wire logic              set_priority,
    input  wire logic              ack_latch,
    input  wire logic              ack_end,
    input  wire pic_pkg::irq_vec_t ir,
    input  wire pic_pkg::irq_vec_t irq_mask,
    input  wire pic_pkg::level_t   eoi_level,
    input  wire pic_pkg::level_t   priority_level,
    output logic                   request_pending,
    output pic_pkg::irq_vec_t      irr,
    output pic_pkg::irq_vec_t      isr,
    output pic_pkg::level_t        ack_level
);

    pic_pkg::irq_vec_t ir_sample;
    pic_pkg::irq_vec_t ir_last;
    pic_pkg::irq_vec_t irr_next;
    pic_pkg::irq_vec_t isr_next;
    pic_pkg::level_t   lowest;
    pic_pkg::level_t   lowest_next;
    pic_pkg::level_t   req_level;
    pic_pkg::level_t   req_rank;
    pic_pkg::level_t   isr_level;
    pic_pkg::level_t   isr_rank;
    logic              req_found;
    logic              isr_found;

    // Scan from lowest to highest priority so the last hit wins
    always_comb begin
        pic_pkg::level_t idx;
        req_found = 1'b0;
        req_level = lowest;
        req_rank  = '1;
        isr_found = 1'b0;
        isr_level = lowest;
        isr_rank  = '1;
        for (int i = `PIC_IRQ_COUNT - 1; i >= 0; i--) begin
            idx = lowest + pic_pkg::level_t'(i) + 3'd1;
            if (irr[idx] && !irq_mask[idx]) begin
                req_found = 1'b1;
                req_level = idx;
                req_rank  = pic_pkg::level_t'(i);
            end
            if (isr[idx]) begin
                isr_found = 1'b1;
                isr_level = idx;
                isr_rank  = pic_pkg::level_t'(i);
            end
        end
    end

    assign request_pending = req_found && (!isr_found || (req_rank < isr_rank));

    always_comb begin
        irr_next    = level_triggered ? ir_sample : (irr | (ir_sample & ~ir_last));
        isr_next    = isr;
        lowest_next = lowest;
        if (ack_latch && req_found) begin
            irr_next[req_level] = 1'b0;
            isr_next[req_level] = 1'b1;
        end
        if (ack_end && auto_eoi) begin
            isr_next[ack_level] = 1'b0;
        end
        if (eoi_pulse) begin
            if (eoi_specific) begin
                isr_next[eoi_level] = 1'b0;
            end else if (isr_found) begin
                isr_next[isr_level] = 1'b0;
                if (eoi_rotate) begin
                    lowest_next = isr_level;
                end
            end
        end
        if (set_priority) begin
            lowest_next = priority_level;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ir_sample <= '0;
            ir_last   <= '0;
        end else begin
            ir_sample <= ir;
            ir_last   <= ir_sample;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || init_clear) begin
            irr    <= '0;
            isr    <= '0;
            lowest <= '1;
        end else begin
            irr    <= irr_next;
            isr    <= isr_next;
            lowest <= lowest_next;
        end
    end

    // Nothing pending at acknowledge gives level 7
    always_ff @(posedge clk) begin
        if (ack_latch) begin
            ack_level <= req_found ? req_level : '1;
        end
    end

endmodule

`default_nettype wire

/* src/bus_output.sv */
`default_nettype none

module bus_output (
    input  wire logic                  rd,
    input  wire logic                  a0,
    input  wire logic                  inta_n,
    input  wire logic                  read_isr,
    input  wire pic_pkg::ack_state_t   ack_state,
    input  wire pic_pkg::vector_base_t vector_base,
    input  wire pic_pkg::level_t       ack_level,
    input  wire pic_pkg::irq_vec_t     irr,
    input  wire pic_pkg::irq_vec_t     isr,
    input  wire pic_pkg::irq_vec_t     irq_mask,
    output pic_pkg::data_t             dout,
    output logic                       dout_en
);

    logic ack_active;

    assign ack_active = (ack_state != pic_pkg::ACK_IDLE);

    always_comb begin
        dout    = '0;
        dout_en = 1'b0;
        if ((ack_state == pic_pkg::ACK_SECOND) && !inta_n) begin
            // 8086 vector byte
            dout    = {vector_base, ack_level};
            dout_en = 1'b1;
        end else if (rd && !ack_active) begin
            dout_en = 1'b1;
            if (a0) begin
                dout = irq_mask;
            end else if (read_isr) begin
                dout = isr;
            end else begin
                dout = irr;
            end
        end
    end

endmodule

`default_nettype wire

/* src/pic_top.sv */
`default_nettype none

module pic_top (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             wr,
    input  wire logic             rd,
    input  wire logic             a0,
    input  wire pic_pkg::data_t   din,
    input  wire pic_pkg::irq_vec_t ir,
    input  wire logic             inta_n,
    output pic_pkg::data_t        dout,
    output logic                  dout_en,
    output logic                  interrupt_to_cpu
);

    logic                  init_clear;
    logic                  level_triggered;
    logic                  auto_eoi;
    logic                  eoi_pulse;
    logic                  eoi_specific;
    logic                  eoi_rotate;
    logic                  set_priority;
    logic                  read_isr;
    pic_pkg::irq_vec_t     irq_mask;
    pic_pkg::level_t       eoi_level;
    pic_pkg::level_t       priority_level;
    pic_pkg::vector_base_t vector_base;
    logic                  request_pending;
    pic_pkg::irq_vec_t     irr;
    pic_pkg::irq_vec_t     isr;
    pic_pkg::level_t       ack_level;
    logic                  ack_latch;
    logic                  ack_end;
    pic_pkg::ack_state_t   ack_state;

    command_decoder i_command_decoder (
        .clk             (clk),
        .rst             (rst),
        .wr              (wr),
        .a0              (a0),
        .din             (din),
        .init_clear      (init_clear),
        .eoi_pulse       (eoi_pulse),
        .eoi_specific    (eoi_specific),
        .eoi_rotate      (eoi_rotate),
        .set_priority    (set_priority),
        .level_triggered (level_triggered),
        .auto_eoi        (auto_eoi),
        .read_isr        (read_isr),
        .irq_mask        (irq_mask),
        .eoi_level       (eoi_level),
        .priority_level  (priority_level),
        .vector_base     (vector_base)
    );

    priority_resolver i_priority_resolver (
        .clk             (clk),
        .rst             (rst),
        .init_clear      (init_clear),
        .level_triggered (level_triggered),
        .auto_eoi        (auto_eoi),
        .eoi_pulse       (eoi_pulse),
        .eoi_specific    (eoi_specific),
        .eoi_rotate      (eoi_rotate),
        .set_priority    (set_priority),
        .ack_latch       (ack_latch),
        .ack_end         (ack_end),
        .ir              (ir),
        .irq_mask        (irq_mask),
        .eoi_level       (eoi_level),
        .priority_level  (priority_level),
        .request_pending (request_pending),
        .irr             (irr),
        .isr             (isr),
        .ack_level       (ack_level)
    );

    ack_sequencer i_ack_sequencer (
        .clk              (clk),
        .rst              (rst),
        .init_clear       (init_clear),
        .inta_n           (inta_n),
        .request_pending  (request_pending),
        .ack_latch        (ack_latch),
        .ack_end          (ack_end),
        .interrupt_to_cpu (interrupt_to_cpu),
        .ack_state        (ack_state)
    );

    bus_output i_bus_output (
        .rd          (rd),
        .a0          (a0),
        .inta_n      (inta_n),
        .read_isr    (read_isr),
        .ack_state   (ack_state),
        .vector_base (vector_base),
        .ack_level   (ack_level),
        .irr         (irr),
        .isr         (isr),
        .irq_mask    (irq_mask),
        .dout        (dout),
        .dout_en     (dout_en)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`default_nettype none

module tb_clock #(
    parameter int period       = 100,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Reset released on a falling edge like the other inputs
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* testbench/tb_pic.sv */
`default_nettype none

module tb_pic;

    localparam int clk_period = 100;

    // Command bytes
    localparam logic [7:0] icw1_edge         = 8'h11;
    localparam logic [7:0] icw1_level        = 8'h19;
    localparam logic [7:0] icw2_base         = 8'h48;
    localparam logic [7:0] icw4_normal       = 8'h01;
    localparam logic [7:0] icw4_auto_eoi     = 8'h03;
    localparam logic [7:0] ocw2_nseoi        = 8'h20;
    localparam logic [7:0] ocw2_seoi         = 8'h60;
    localparam logic [7:0] ocw2_rotate_eoi   = 8'ha0;
    localparam logic [7:0] ocw2_set_priority = 8'hc0;
    localparam logic [7:0] ocw3_read_irr     = 8'h0a;
    localparam logic [7:0] ocw3_read_isr     = 8'h0b;

    localparam logic [31:0] lfsr_taps = 32'h8020_0003;
    localparam logic [31:0] lfsr_seed = 32'h3c2e_b0b6;

    // Each service takes a wait plus acknowledge plus read and EOI
    localparam int wait_limit     = 20;
    localparam int service_cycles = 40;
    localparam int total_cycles   = 3 + 40 + 60 + (8 * service_cycles + 40) +
                                    4 * service_cycles + (2 * service_cycles + 40) +
                                    (9 * service_cycles + 40) + 200;

    logic        clk;
    logic        rst;
    logic        wr;
    logic        rd;
    logic        a0;
    logic [7:0]  din;
    logic [7:0]  ir;
    logic        inta_n;
    logic [7:0]  dout;
    logic        dout_en;
    logic        interrupt_to_cpu;

    int          errors;
    int          checks;
    logic [31:0] lfsr_state;
    logic [7:0]  model_base;
    int          model_lowest;

    tb_clock #(
        .period       (clk_period),
        .reset_cycles (3)
    ) i_tb_clock (
        .clk (clk),
        .rst (rst)
    );

    pic_top i_pic_top (
        .clk              (clk),
        .rst              (rst),
        .wr               (wr),
        .rd               (rd),
        .a0               (a0),
        .din              (din),
        .ir               (ir),
        .inta_n           (inta_n),
        .dout             (dout),
        .dout_en          (dout_en),
        .interrupt_to_cpu (interrupt_to_cpu)
    );

    function automatic logic [7:0] random_bits(input int count);
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps) : (lfsr_state >> 1);
            value = {value[6:0], lfsr_state[0]};
        end
        random_bits = value;
    endfunction

    // First pending level counting up from the one after the lowest priority
    function automatic int next_level(input logic [7:0] pending, input int lowest);
        int k;
        k = 1;
        next_level = -1;
        while (next_level < 0 && k <= 8) begin
            if (pending[(lowest + k) % 8]) begin
                next_level = (lowest + k) % 8;
            end
            k++;
        end
    endfunction

    function automatic logic [7:0] vector_for(input int lvl);
        vector_for = {model_base[7:3], lvl[2:0]};
    endfunction

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic write_reg(input logic addr, input logic [7:0] data);
        @(negedge clk);
        wr  = 1'b1;
        a0  = addr;
        din = data;
        @(negedge clk);
        wr  = 1'b0;
        a0  = 1'b0;
        din = 8'h00;
    endtask

    task automatic read_check(input logic addr, input logic [7:0] expected, input string name);
        @(negedge clk);
        rd = 1'b1;
        a0 = addr;
        @(negedge clk);
        check_value("dout_en", dout_en, 8'h01);
        check_value(name, dout, expected);
        rd = 1'b0;
        a0 = 1'b0;
    endtask

    task automatic idle_check(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("interrupt_to_cpu", interrupt_to_cpu, 8'h00);
        end
    endtask

    task automatic wait_for_interrupt(input int limit);
        int n;
        n = 0;
        while (!interrupt_to_cpu && n < limit) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (interrupt_to_cpu) else begin
            errors++;
            $display("Error: interrupt_to_cpu was not raised within %0d cycles at %0t",
                     limit, $time);
        end
    endtask

    // Vector is checked while the second INTA pulse is low
    task automatic acknowledge(input logic [7:0] expected);
        @(negedge clk);
        inta_n = 1'b0;
        @(negedge clk);
        inta_n = 1'b1;
        @(negedge clk);
        inta_n = 1'b0;
        @(negedge clk);
        check_value("dout_en", dout_en, 8'h01);
        check_value("dout vector", dout, expected);
        inta_n = 1'b1;
        @(negedge clk);
        check_value("interrupt_to_cpu", interrupt_to_cpu, 8'h00);
    endtask

    task automatic configure(input logic [7:0] icw1, input logic [7:0] icw4,
                             input logic [7:0] mask);
        write_reg(1'b0, icw1);
        write_reg(1'b1, icw2_base);
        write_reg(1'b1, icw4);
        write_reg(1'b1, mask);
        write_reg(1'b0, ocw3_read_isr);
        model_base   = icw2_base & 8'hf8;
        model_lowest = 7;
    endtask

    task automatic serve_one(input int lvl, input logic [7:0] eoi_cmd);
        wait_for_interrupt(wait_limit);
        acknowledge(vector_for(lvl));
        read_check(1'b0, 8'h01 << lvl, "dout isr");
        write_reg(1'b0, eoi_cmd);
    endtask

    task automatic serve_all(input logic [7:0] requests);
        logic [7:0] pending;
        int         lvl;
        pending = requests;
        while (pending != 8'h00) begin
            lvl = next_level(pending, model_lowest);
            serve_one(lvl, ocw2_nseoi);
            pending[lvl] = 1'b0;
        end
    endtask

    task automatic reset_and_init_sequence();
        logic [7:0] mask;
        check_value("interrupt_to_cpu", interrupt_to_cpu, 8'h00);
        check_value("dout_en", dout_en, 8'h00);
        read_check(1'b1, 8'hff, "dout imr");
        mask = random_bits(8);
        configure(icw1_edge, icw4_normal, mask);
        read_check(1'b1, mask, "dout imr");
    endtask

    task automatic single_request_vector();
        int lvl;
        lvl = random_bits(3);
        configure(icw1_edge, icw4_normal, 8'h00);
        @(negedge clk);
        ir = 8'h01 << lvl;
        // Sampled at the first edge and raised at the third
        @(negedge clk);
        check_value("interrupt_to_cpu", interrupt_to_cpu, 8'h00);
        @(negedge clk);
        check_value("interrupt_to_cpu", interrupt_to_cpu, 8'h00);
        @(negedge clk);
        check_value("interrupt_to_cpu", interrupt_to_cpu, 8'h01);
        acknowledge(vector_for(lvl));
        write_reg(1'b0, ocw2_nseoi);
        ir = 8'h00;
    endtask

    task automatic fixed_priority_order();
        logic [7:0] requests;
        requests = random_bits(8);
        if (requests == 8'h00) begin
            requests = 8'h81;
        end
        configure(icw1_edge, icw4_normal, 8'h00);
        @(negedge clk);
        ir = requests;
        serve_all(requests);
        idle_check(10);
        ir = 8'h00;
    endtask

    task automatic masking_and_triggering();
        configure(icw1_edge, icw4_normal, 8'h20);
        write_reg(1'b0, ocw3_read_irr);
        @(negedge clk);
        ir = 8'h20;
        idle_check(8);
        read_check(1'b0, 8'h20, "dout irr");
        ir = 8'h00;
        // Held request in edge mode comes only once
        configure(icw1_edge, icw4_normal, 8'h00);
        @(negedge clk);
        ir = 8'h08;
        serve_one(3, ocw2_nseoi);
        idle_check(10);
        ir = 8'h00;
        configure(icw1_level, icw4_normal, 8'h00);
        @(negedge clk);
        ir = 8'h40;
        serve_one(6, ocw2_nseoi);
        wait_for_interrupt(wait_limit);
        ir = 8'h00;
    endtask

    task automatic eoi_mode_behavior();
        configure(icw1_edge, icw4_auto_eoi, 8'h00);
        @(negedge clk);
        ir = 8'h04;
        wait_for_interrupt(wait_limit);
        acknowledge(vector_for(2));
        read_check(1'b0, 8'h00, "dout isr");
        ir = 8'h00;
        configure(icw1_edge, icw4_normal, 8'h00);
        @(negedge clk);
        ir = 8'h10;
        wait_for_interrupt(wait_limit);
        acknowledge(vector_for(4));
        read_check(1'b0, 8'h10, "dout isr");
        write_reg(1'b0, ocw2_seoi | 8'h01);
        read_check(1'b0, 8'h10, "dout isr");
        write_reg(1'b0, ocw2_seoi | 8'h04);
        read_check(1'b0, 8'h00, "dout isr");
        ir = 8'h00;
    endtask

    task automatic priority_rotation();
        int lvl;
        configure(icw1_edge, icw4_normal, 8'h00);
        model_lowest = random_bits(3);
        write_reg(1'b0, ocw2_set_priority | model_lowest[2:0]);
        @(negedge clk);
        ir = 8'hff;
        lvl = next_level(8'hff, model_lowest);
        serve_one(lvl, ocw2_rotate_eoi);
        model_lowest = lvl;
        // New edge on the serviced level which is now lowest in line
        @(negedge clk);
        ir[lvl] = 1'b0;
        @(negedge clk);
        @(negedge clk);
        ir[lvl] = 1'b1;
        serve_all(8'hff);
        ir = 8'h00;
    endtask

    // No read and INTA high means the bus is released
    always @(posedge clk) begin
        if (!rd && inta_n) begin
            assert (!dout_en) else begin
                errors++;
                $display("** Error: dout_en is %h with rd and inta_n inactive at %0t",
                         dout_en, $time);
            end
        end
    end

    initial begin
        #(total_cycles * clk_period);
        $display("Watchdog expired after %0d cycles, checks: %0d, errors: %0d",
                 total_cycles, checks, errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        wr           = 1'b0;
        rd           = 1'b0;
        a0           = 1'b0;
        din          = 8'h00;
        ir           = 8'h00;
        inta_n       = 1'b1;
        errors       = 0;
        checks       = 0;
        lfsr_state   = lfsr_seed;
        model_base   = 8'h00;
        model_lowest = 7;
        wait (rst === 1'b0);
        @(negedge clk);
        reset_and_init_sequence();
        single_request_vector();
        fixed_priority_order();
        masking_and_triggering();
        eoi_mode_behavior();
        priority_rotation();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
